// File: Bender.yml
package:
  name: exe_stage

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/exePkg.sv
      - src/alu.sv
      - src/branchUnit.sv
      - src/mulDiv.sv
      - src/dataMem.sv
      - src/exeStage.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/exeStage_asserts.sv
      - verification/exeChecker.sv
      - verification/exeStage_tb.sv

// File: src.f
+incdir+src
src/exePkg.sv
src/alu.sv
src/branchUnit.sv
src/mulDiv.sv
src/dataMem.sv
src/exeStage.sv
verification/exeStage_asserts.sv
verification/exeChecker.sv
verification/exeStage_tb.sv

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module alu (
	input exePkg::aluOp_e op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result,
	output logic zero
);
	import exePkg::*;

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = b[4:0]; // only low five bits shift
	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb
	begin
		case (op)
			ADD:
				result = a + b;
			SUB:
				result = a - b;
			SLL:
				result = a << shamt;
			SLT:
				result = {{(`XLEN-1){1'b0}}, lessSigned};
			SLTU:
				result = {{(`XLEN-1){1'b0}}, lessUnsigned};
			XOR:
				result = a ^ b;
			SRL:
				result = a >> shamt;
			SRA:
				result = $signed(a) >>> shamt; // keeps sign bit
			OR:
				result = a | b;
			AND:
				result = a & b;
			default:
				result = '0;
		endcase
	end

	// equality test for branches when op is SUB
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: src/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module branchUnit (
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic isBranch,
	input logic branchNeq,
	input logic jal,
	input logic jalr,
	input logic zero,
	output logic [`XLEN-1:0] target,
	output logic taken
);

	logic [`XLEN-1:0] jalrSum;
	logic condMet;

	assign jalrSum = a + b;

	// beq wants zero set, bne wants it clear
	assign condMet = (zero == ~branchNeq);

	assign taken = (isBranch & condMet) | jal | jalr;

	always_comb
	begin
		if (jalr)
			target = {jalrSum[`XLEN-1:1], 1'b0}; // lsb cleared per spec
		else if (jal)
			target = pc + jImm;
		else
			target = pc + bImm;
	end

endmodule

`default_nettype wire

// File: src/dataMem.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module dataMem (
	input logic clk,
	input logic nrst,
	input exePkg::memOp_e op,
	input logic [`XLEN-1:0] base,
	input logic [`XLEN-1:0] loadOff,
	input logic [`XLEN-1:0] storeOff,
	input logic [`XLEN-1:0] storeData,
	output logic [`XLEN-1:0] loadData,
	output logic misaligned
);
	import exePkg::*;

	localparam int IdxW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] mem [`DMEM_WORDS];
	logic isLoad;
	logic isStore;
	logic [`XLEN-1:0] addr;
	logic [1:0] byteOff;
	logic [IdxW-1:0] wordIdx;
	logic badAlign;
	logic [3:0] byteEn;
	logic [`XLEN-1:0] wrWord;
	logic [`XLEN-1:0] rdWord;
	logic [`XLEN-1:0] shifted;
	logic [`XLEN-1:0] extData;

	assign isLoad = op inside {LB, LH, LW, LBU, LHU};
	assign isStore = op inside {SB, SH, SW};
	assign addr = isStore ? base + storeOff : base + loadOff;
	assign byteOff = addr[1:0];
	assign wordIdx = addr[IdxW+1:2]; // upper bits dropped, address wraps

	always_comb
	begin
		case (op)
			LH, LHU, SH:
				badAlign = addr[0];
			LW, SW:
				badAlign = (byteOff != 2'b00);
			default:
				badAlign = 1'b0;
		endcase
	end

	// byte lanes and replicated store data
	always_comb
	begin
		byteEn = 4'b0000;
		wrWord = storeData;
		case (op)
			SB:
			begin
				byteEn = 4'b0001 << byteOff;
				wrWord = {4{storeData[7:0]}};
			end
			SH:
			begin
				byteEn = 4'b0011 << byteOff;
				wrWord = {2{storeData[15:0]}};
			end
			SW:
				byteEn = 4'b1111;
			default:
				byteEn = 4'b0000;
		endcase
		if (badAlign)
			byteEn = 4'b0000; // misaligned store never reaches the array
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (byteEn[i])
				mem[wordIdx][8*i +: 8] <= wrWord[8*i +: 8];
		end
	end

	assign rdWord = mem[wordIdx];
	assign shifted = rdWord >> {byteOff, 3'b000};

	always_comb
	begin
		case (op)
			LB:
				extData = {{24{shifted[7]}}, shifted[7:0]};
			LBU:
				extData = {24'b0, shifted[7:0]};
			LH:
				extData = {{16{shifted[15]}}, shifted[15:0]};
			LHU:
				extData = {16'b0, shifted[15:0]};
			default:
				extData = rdWord; // LW
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			loadData <= '0;
			misaligned <= 1'b0;
		end
		else
		begin
			loadData <= (isLoad && !badAlign) ? extData : '0;
			misaligned <= badAlign;
		end
	end

endmodule

`default_nettype wire

// File: src/exePkg.sv
`default_nettype none

package exePkg;

	// integer ALU operations
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		SLL  = 4'd2,
		SLT  = 4'd3,
		SLTU = 4'd4,
		XOR  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		OR   = 4'd8,
		AND  = 4'd9
	} aluOp_e;

	// write-back source select
	typedef enum logic [2:0] {
		ALU    = 3'd0,
		LINK   = 3'd1, // pc + 4
		MULDIV = 3'd2,
		LUI    = 3'd3,
		LOAD   = 3'd4,
		AUIPC  = 3'd5
	} wbSel_e;

	typedef enum logic [3:0] {
		NONE = 4'd0,
		LB   = 4'd1,
		LH   = 4'd2,
		LW   = 4'd3,
		LBU  = 4'd4,
		LHU  = 4'd5,
		SB   = 4'd6,
		SH   = 4'd7,
		SW   = 4'd8
	} memOp_e;

	// RV32M funct3 order
	typedef enum logic [2:0] {
		MUL    = 3'd0,
		MULH   = 3'd1,
		MULHSU = 3'd2,
		MULHU  = 3'd3,
		DIV    = 3'd4,
		DIVU   = 3'd5,
		REM    = 3'd6,
		REMU   = 3'd7
	} mulDivOp_e;

endpackage

`default_nettype wire

// File: src/exeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module exeStage (
	input logic clk,
	input logic nrst,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic [`XLEN-1:0] uImm,
	input logic [`XLEN-1:0] sImm,
	input logic [`XLEN-1:0] pc,
	input logic [4:0] rd,
	input logic we,
	input logic isBranch,
	input logic branchNeq,
	input logic jal,
	input logic jalr,
	input logic ecall,
	input logic instrMisaligned,
	input exePkg::aluOp_e aluOp,
	input exePkg::wbSel_e wbSel,
	input exePkg::memOp_e memOp,
	input exePkg::mulDivOp_e mulDivOp,
	output logic [`XLEN-1:0] wbData,
	output logic [`XLEN-1:0] target,
	output logic [`XLEN-1:0] pcExc,
	output logic [`XLEN-1:0] mCause,
	output logic [4:0] wbRd,
	output logic wbWe,
	output logic bjTaken,
	output logic exceptionPending
);
	import exePkg::*;

	// stage 5
	logic [`XLEN-1:0] opA5;
	logic [`XLEN-1:0] opB5;
	logic [`XLEN-1:0] bImm5;
	logic [`XLEN-1:0] jImm5;
	logic [`XLEN-1:0] uImm5;
	logic [`XLEN-1:0] sImm5;
	logic [`XLEN-1:0] pc5;
	logic [4:0] rd5;
	logic we5;
	logic isBranch5;
	logic branchNeq5;
	logic jal5;
	logic jalr5;
	logic ecall5;
	logic instrMisaligned5;
	aluOp_e aluOp5;
	wbSel_e wbSel5;
	memOp_e memOp5;
	mulDivOp_e mulDivOp5;
	logic [`XLEN-1:0] aluRes5;
	logic aluZero5;
	logic [`XLEN-1:0] mulDivRes5;
	logic isStore5;

	// stage 6
	logic [`XLEN-1:0] aluRes6;
	logic [`XLEN-1:0] mulDivRes6;
	logic [`XLEN-1:0] uImm6;
	logic [`XLEN-1:0] auipc6;
	logic [`XLEN-1:0] pc6;
	logic [4:0] rd6;
	logic we6;
	wbSel_e wbSel6;
	logic ecall6;
	logic instrMisaligned6;
	logic isStore6;
	logic [`XLEN-1:0] loadData6;
	logic memMisaligned6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opA5 <= '0;
			opB5 <= '0;
			bImm5 <= '0;
			jImm5 <= '0;
			uImm5 <= '0;
			sImm5 <= '0;
			pc5 <= '0;
			rd5 <= '0;
			we5 <= 1'b0;
			isBranch5 <= 1'b0;
			branchNeq5 <= 1'b0;
			jal5 <= 1'b0;
			jalr5 <= 1'b0;
			ecall5 <= 1'b0;
			instrMisaligned5 <= 1'b0;
			aluOp5 <= ADD;
			wbSel5 <= ALU;
			memOp5 <= NONE;
			mulDivOp5 <= MUL;
		end
		else
		begin
			opA5 <= opA;
			opB5 <= opB;
			bImm5 <= bImm;
			jImm5 <= jImm;
			uImm5 <= uImm;
			sImm5 <= sImm;
			pc5 <= pc;
			rd5 <= rd;
			we5 <= we;
			isBranch5 <= isBranch;
			branchNeq5 <= branchNeq;
			jal5 <= jal;
			jalr5 <= jalr;
			ecall5 <= ecall;
			instrMisaligned5 <= instrMisaligned;
			aluOp5 <= aluOp;
			wbSel5 <= wbSel;
			memOp5 <= memOp;
			mulDivOp5 <= mulDivOp;
		end
	end

	alu alu0 (
		.op(aluOp5),
		.a(opA5),
		.b(opB5),
		.result(aluRes5),
		.zero(aluZero5)
	);

	branchUnit bru0 (
		.pc(pc5),
		.a(opA5),
		.b(opB5),
		.bImm(bImm5),
		.jImm(jImm5),
		.isBranch(isBranch5),
		.branchNeq(branchNeq5),
		.jal(jal5),
		.jalr(jalr5),
		.zero(aluZero5),
		.target(target),
		.taken(bjTaken)
	);

	mulDiv mdu0 (
		.op(mulDivOp5),
		.a(opA5),
		.b(opB5),
		.result(mulDivRes5)
	);

	// load and store data both come from the stage 5 operands
	dataMem dmem0 (
		.clk(clk),
		.nrst(nrst),
		.op(memOp5),
		.base(opA5),
		.loadOff(opB5),
		.storeOff(sImm5),
		.storeData(opB5),
		.loadData(loadData6),
		.misaligned(memMisaligned6)
	);

	assign isStore5 = memOp5 inside {SB, SH, SW}; // splits load and store cause

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			aluRes6 <= '0;
			mulDivRes6 <= '0;
			uImm6 <= '0;
			auipc6 <= '0;
			pc6 <= '0;
			rd6 <= '0;
			we6 <= 1'b0;
			wbSel6 <= ALU;
			ecall6 <= 1'b0;
			instrMisaligned6 <= 1'b0;
			isStore6 <= 1'b0;
		end
		else
		begin
			aluRes6 <= aluRes5;
			mulDivRes6 <= mulDivRes5;
			uImm6 <= uImm5;
			auipc6 <= pc5 + uImm5;
			pc6 <= pc5;
			rd6 <= rd5;
			we6 <= we5;
			wbSel6 <= wbSel5;
			ecall6 <= ecall5;
			instrMisaligned6 <= instrMisaligned5;
			isStore6 <= isStore5;
		end
	end

	always_comb
	begin
		case (wbSel6)
			ALU:
				wbData = aluRes6;
			LINK:
				wbData = pc6 + `XLEN'd4; // return address
			MULDIV:
				wbData = mulDivRes6;
			LUI:
				wbData = uImm6;
			LOAD:
				wbData = loadData6;
			AUIPC:
				wbData = auipc6;
			default:
				wbData = '0;
		endcase
	end

	assign exceptionPending = instrMisaligned6 | ecall6 | memMisaligned6;

	// earliest cause wins
	always_comb
	begin
		if (instrMisaligned6)
			mCause = `CAUSE_INSTR_MISALIGNED;
		else if (ecall6)
			mCause = `CAUSE_ECALL_M;
		else if (memMisaligned6 && !isStore6)
			mCause = `CAUSE_LOAD_MISALIGNED;
		else if (memMisaligned6)
			mCause = `CAUSE_STORE_MISALIGNED;
		else
			mCause = '0;
	end

	assign pcExc = pc6;
	assign wbRd = rd6;
	assign wbWe = we6 & ~exceptionPending; // trapping instruction never retires

endmodule

`default_nettype wire

// File: src/exe_consts.svh
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// datapath and address width
`define XLEN 32

// data memory depth in 32-bit words
`define DMEM_WORDS 256

// machine cause codes, interrupt bit always clear
`define CAUSE_INSTR_MISALIGNED 32'd0
`define CAUSE_LOAD_MISALIGNED 32'd4
`define CAUSE_STORE_MISALIGNED 32'd6
`define CAUSE_ECALL_M 32'd11

`endif

// File: src/mulDiv.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module mulDiv (
	input exePkg::mulDivOp_e op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result
);
	import exePkg::*;

	logic aSigned;
	logic bSigned;
	logic [2*`XLEN-1:0] aExt;
	logic [2*`XLEN-1:0] bExt;
	logic [2*`XLEN-1:0] product;
	logic divZero;
	logic overflow;
	logic [`XLEN-1:0] quotSigned;
	logic [`XLEN-1:0] remSigned;

	// only MULH and MULHSU sign-extend a
	assign aSigned = (op == MULH) || (op == MULHSU);
	assign bSigned = (op == MULH);
	assign aExt = {{`XLEN{aSigned & a[`XLEN-1]}}, a};
	assign bExt = {{`XLEN{bSigned & b[`XLEN-1]}}, b};
	assign product = aExt * bExt; // low 64 bits are exact for all signedness mixes

	assign divZero = (b == '0);
	assign overflow = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);

	assign quotSigned = $signed(a) / $signed(b); // rounds toward zero
	assign remSigned = $signed(a) % $signed(b); // takes the dividend's sign

	always_comb
	begin
		case (op)
			MUL:
				result = product[`XLEN-1:0];
			MULH, MULHSU, MULHU:
				result = product[2*`XLEN-1:`XLEN];
			DIV:
				result = divZero ? '1 : (overflow ? a : quotSigned);
			DIVU:
				result = divZero ? '1 : a / b;
			REM:
				result = divZero ? a : (overflow ? '0 : remSigned);
			REMU:
				result = divZero ? a : a % b;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verification/exeChecker.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module exeChecker (
	input logic clk,
	input logic nrst,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic [`XLEN-1:0] uImm,
	input logic [`XLEN-1:0] sImm,
	input logic [`XLEN-1:0] pc,
	input logic [4:0] rd,
	input logic we,
	input logic isBranch,
	input logic branchNeq,
	input logic jal,
	input logic jalr,
	input logic ecall,
	input logic instrMisaligned,
	input exePkg::aluOp_e aluOp,
	input exePkg::wbSel_e wbSel,
	input exePkg::memOp_e memOp,
	input exePkg::mulDivOp_e mulDivOp,
	input logic [`XLEN-1:0] wbData,
	input logic [`XLEN-1:0] target,
	input logic [`XLEN-1:0] pcExc,
	input logic [`XLEN-1:0] mCause,
	input logic [4:0] wbRd,
	input logic wbWe,
	input logic bjTaken,
	input logic exceptionPending,
	output int errCount,
	output int checkCount
);
	import exePkg::*;

	localparam int MemBytes = `DMEM_WORDS * 4;

	logic [7:0] memModel [MemBytes]; // byte image, little endian

	// expectations one edge after issue
	logic [`XLEN-1:0] eTarget5;
	logic eTaken5;
	logic eCtl5; // branch or jump, target is meaningful
	// expectations two edges after issue, staged here first
	logic [`XLEN-1:0] eData5, eData6;
	logic [`XLEN-1:0] eCause5, eCause6;
	logic [`XLEN-1:0] ePc5, ePc6;
	logic [4:0] eRd5, eRd6;
	logic eWe5, eWe6;
	logic eExc5, eExc6;

	initial
	begin
		errCount = 0;
		checkCount = 0;
	end

	function automatic logic [`XLEN-1:0] aluRef(aluOp_e op, logic [`XLEN-1:0] a,
		logic [`XLEN-1:0] b);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			SLL: return a << b[4:0];
			SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			SLTU: return (a < b) ? 32'd1 : 32'd0;
			XOR: return a ^ b;
			SRL: return a >> b[4:0];
			SRA: return $signed(a) >>> b[4:0];
			OR: return a | b;
			AND: return a & b;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] mulDivRef(mulDivOp_e op, logic [`XLEN-1:0] a,
		logic [`XLEN-1:0] b);
		longint sa;
		longint sb;
		longint ua;
		longint ub;
		logic [63:0] p;
		sa = $signed(a);
		sb = $signed(b);
		ua = {32'b0, a};
		ub = {32'b0, b};
		case (op)
			MUL, MULH: p = sa * sb;
			MULHSU: p = sa * ub;
			MULHU: p = ua * ub; // bit pattern wraps mod 2^64
			default: p = 64'd0;
		endcase
		if (op == MUL)
			return p[31:0];
		if (op inside {MULH, MULHSU, MULHU})
			return p[63:32];
		if (b == 32'd0)
			return (op inside {DIV, DIVU}) ? 32'hffffffff : a;
		if (op == DIV)
			return (a == 32'h80000000 && b == 32'hffffffff) ? a : 32'(sa / sb);
		if (op == REM)
			return (a == 32'h80000000 && b == 32'hffffffff) ? 32'd0 : 32'(sa % sb);
		if (op == DIVU)
			return 32'(ua / ub);
		return 32'(ua % ub);
	endfunction

	task automatic compareValue(string name, logic [`XLEN-1:0] expected,
		logic [`XLEN-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errCount++;
			$display("CHECK FAILED time=%0t %s expected=%h actual=%h",
				$time, name, expected, actual);
		end
	endtask

	always @(posedge clk)
	begin : model
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] ld;
		int size;
		logic mis;
		logic isStore;
		if (!nrst)
		begin
			{eTarget5, eTaken5, eCtl5} = '0;
			{eData5, eCause5, ePc5, eRd5, eWe5, eExc5} = '0;
			{eData6, eCause6, ePc6, eRd6, eWe6, eExc6} = '0;
		end
		else
		begin
			// older instruction moves on
			eData6 = eData5;
			eCause6 = eCause5;
			ePc6 = ePc5;
			eRd6 = eRd5;
			eWe6 = eWe5;
			eExc6 = eExc5;

			eTaken5 = (isBranch && ((opA == opB) != branchNeq)) || jal || jalr;
			eCtl5 = isBranch || jal || jalr;
			if (jalr)
				eTarget5 = (opA + opB) & ~32'd1;
			else if (jal)
				eTarget5 = pc + jImm;
			else
				eTarget5 = pc + bImm;

			isStore = memOp inside {SB, SH, SW};
			size = 0;
			if (memOp inside {LB, LBU, SB})
				size = 1;
			else if (memOp inside {LH, LHU, SH})
				size = 2;
			else if (memOp inside {LW, SW})
				size = 4;
			addr = isStore ? opA + sImm : opA + opB;
			mis = (size > 1) && (addr % size != 0);
			ld = '0;
			if (size > 0 && !mis)
			begin
				for (int k = 0; k < size; k++)
				begin
					if (isStore)
						memModel[(addr + k) % MemBytes] = opB[8*k +: 8];
					else
						ld[8*k +: 8] = memModel[(addr + k) % MemBytes];
				end
				if (memOp == LB)
					ld = {{24{ld[7]}}, ld[7:0]};
				else if (memOp == LH)
					ld = {{16{ld[15]}}, ld[15:0]};
			end

			eExc5 = instrMisaligned || ecall || mis;
			if (instrMisaligned)
				eCause5 = `CAUSE_INSTR_MISALIGNED;
			else if (ecall)
				eCause5 = `CAUSE_ECALL_M;
			else if (mis)
				eCause5 = isStore ? `CAUSE_STORE_MISALIGNED : `CAUSE_LOAD_MISALIGNED;
			else
				eCause5 = '0;

			case (wbSel)
				LINK: eData5 = pc + 32'd4;
				MULDIV: eData5 = mulDivRef(mulDivOp, opA, opB);
				LUI: eData5 = uImm;
				LOAD: eData5 = ld;
				AUIPC: eData5 = pc + uImm;
				default: eData5 = aluRef(aluOp, opA, opB);
			endcase
			eWe5 = we && !eExc5;
			eRd5 = rd;
			ePc5 = pc;
		end
	end

	// mid cycle, all DUT outputs come from registers
	always @(negedge clk)
	begin
		compareValue("bjTaken", eTaken5, bjTaken);
		if (eCtl5)
			compareValue("target", eTarget5, target);
		compareValue("wbWe", eWe6, wbWe);
		compareValue("exceptionPending", eExc6, exceptionPending);
		compareValue("mCause", eCause6, mCause);
		compareValue("pcExc", ePc6, pcExc);
		compareValue("wbRd", eRd6, wbRd);
		if (eWe6)
			compareValue("wbData", eData6, wbData); // only meaningful on write-back
	end

endmodule

`default_nettype wire

// File: verification/exeStage_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module exeStage_asserts (
	input logic clk,
	input logic nrst,
	input logic wbWe,
	input logic bjTaken,
	input logic exceptionPending,
	input logic [`XLEN-1:0] mCause
);

	int assertFails = 0; // read by the testbench at the end

	// a trapping instruction must not retire
	weNotOnTrap: assert property (@(posedge clk) disable iff (!nrst)
		!(wbWe && exceptionPending))
	else
	begin
		assertFails++;
		$error("wbWe high while exceptionPending is high");
	end

	causeTopClear: assert property (@(posedge clk) !mCause[`XLEN-1])
	else
	begin
		assertFails++;
		$error("mCause bit 31 set, no interrupts exist here");
	end

	// pipeline is empty while held in reset
	quietInReset: assert property (@(posedge clk)
		!nrst |-> (!wbWe && !bjTaken && !exceptionPending))
	else
	begin
		assertFails++;
		$error("output active while nrst is low");
	end

endmodule

`default_nettype wire

// File: verification/exeStage_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_consts.svh"

module exeStage_tb;
	import exePkg::*;

	localparam int FillCount = 256;
	localparam int RandCount = 3000;
	localparam int ClkPeriod = 10;

	logic clk = 1'b0;
	logic nrst;
	logic [`XLEN-1:0] opA, opB, bImm, jImm, uImm, sImm, pc;
	logic [4:0] rd;
	logic we, isBranch, branchNeq, jal, jalr, ecall, instrMisaligned;
	aluOp_e aluOp;
	wbSel_e wbSel;
	memOp_e memOp;
	mulDivOp_e mulDivOp;
	logic [`XLEN-1:0] wbData, target, pcExc, mCause;
	logic [4:0] wbRd;
	logic wbWe, bjTaken, exceptionPending;
	int errCount;
	int checkCount;
	int totalErrors;

	exeStage dut0 (.*);

	exeChecker chk0 (.*);

	bind exeStage exeStage_asserts asserts0 (
		.clk(clk),
		.nrst(nrst),
		.wbWe(wbWe),
		.bjTaken(bjTaken),
		.exceptionPending(exceptionPending),
		.mCause(mCause)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	task automatic setIdle();
		{opA, opB, bImm, jImm, uImm, sImm, pc, rd} = '0;
		{we, isBranch, branchNeq, jal, jalr, ecall, instrMisaligned} = '0;
		aluOp = ADD;
		wbSel = ALU;
		memOp = NONE;
		mulDivOp = MUL;
	endtask

	// one aligned word store per memory word
	task automatic fillWord(int idx);
		setIdle();
		opA = idx * 4;
		opB = $urandom;
		memOp = SW;
	endtask

	task automatic driveRandom();
		int kind;
		int lowBits;
		setIdle();
		kind = $urandom % 9;
		opA = $urandom;
		opB = $urandom;
		bImm = $urandom;
		jImm = $urandom;
		uImm = $urandom & 32'hfffff000;
		pc = $urandom & ~32'd3;
		rd = 5'($urandom);
		case (kind)
			0:
			begin
				aluOp = aluOp_e'($urandom % 10);
				we = 1'b1;
			end
			1:
			begin
				isBranch = 1'b1;
				aluOp = SUB; // equality through the ALU zero flag
				branchNeq = 1'($urandom);
				if ($urandom % 2)
					opB = opA;
			end
			2, 3:
			begin
				jal = (kind == 2);
				jalr = (kind == 3);
				wbSel = LINK;
				we = 1'b1;
			end
			4, 5:
			begin
				wbSel = (kind == 4) ? LUI : AUIPC;
				we = 1'b1;
			end
			6:
			begin
				mulDivOp = mulDivOp_e'($urandom % 8);
				wbSel = MULDIV;
				we = 1'b1;
				case ($urandom % 8)
					0: opB = '0; // divide by zero
					1:
					begin
						opA = 32'h80000000; // signed overflow
						opB = '1;
					end
					default: ;
				endcase
			end
			default:
			begin
				memOp = (kind == 7) ? memOp_e'(1 + $urandom % 5) : memOp_e'(6 + $urandom % 3);
				opA = ($urandom % `DMEM_WORDS) * 4; // small base keeps the access in memory
				lowBits = $urandom % 4;
				if ($urandom % 4 != 0)
				begin
					if (memOp inside {LH, LHU, SH})
						lowBits = lowBits & 2;
					else if (memOp inside {LW, SW})
						lowBits = 0;
				end
				if (kind == 7)
				begin
					opB = 4 * ($urandom % 8) + lowBits;
					wbSel = LOAD;
					we = 1'b1;
				end
				else
					sImm = 4 * ($urandom % 8) + lowBits;
			end
		endcase
		ecall = ($urandom % 40 == 0);
		instrMisaligned = ($urandom % 50 == 0);
	endtask

	initial
	begin
		void'($urandom(32'hbf62b01a));
		nrst = 1'b0;
		setIdle();
		repeat (4) @(negedge clk);
		nrst = 1'b1;
		for (int i = 0; i < FillCount; i++)
		begin
			fillWord(i);
			@(negedge clk);
		end
		for (int i = 0; i < RandCount; i++)
		begin
			driveRandom();
			@(negedge clk);
		end
		setIdle();
		repeat (3) @(negedge clk); // drain stages 5 and 6
		totalErrors = errCount + dut0.asserts0.assertFails;
		$display("errors: %0d (assertion failures: %0d), checks: %0d",
			totalErrors, dut0.asserts0.assertFails, checkCount);
		if (totalErrors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#((FillCount + RandCount + 20) * ClkPeriod);
		$display("timeout: the run did not finish in the expected time");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
